/* ccip_lpbk.f */
+incdir+source
source/ccip_lpbk_pkg.sv
source/ccip_rx_decode.sv
source/vtp_xlate.sv
source/nlb_lpbk.sv
source/ccip_tx_encode.sv
source/ccip_lpbk_afu.sv
verification/ccip_lpbk_asserts.sv
verification/tb_ccip_lpbk.sv

/* run_ccip_lpbk.sh */
#!/bin/sh
# Builds the loopback AFU testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_ccip_lpbk \
    -f ccip_lpbk.f --Mdir obj_dir -o tb_ccip_lpbk_sim \
    && ./obj_dir/tb_ccip_lpbk_sim +verilator+error+limit+100 > sim.log 2>&1
grep -q '^=== PASS ===$' sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

/* verification/tb_ccip_lpbk.sv */
// Testbench for the loopback AFU
// A memory model answers tx requests on rx after random delays, so responses
// return out of order, and a table of rows programs the page table and command
// Each row checks read addresses, write data, timing and the done strobe

`timescale 1ns/1ps
`include "ccip_lpbk_defines.svh"

module tb_ccip_lpbk
    import ccip_lpbk_pkg::*;
();

    typedef logic [`CCIP_PPAGE_W+`CCIP_OFFS_W-1:0] t_key;

    // One row of the stimulus table, exp_reads is the expected read count
    typedef struct packed {
        logic [3:0][`CCIP_PPAGE_W-1:0] pt;
        logic [`CCIP_VPAGE_W-1:0]      src;
        logic [`CCIP_VPAGE_W-1:0]      dst;
        t_len                          len;
        logic                          restart;
        t_len                          exp_reads;
    } t_row;

    logic                        afu_clk = 1'b0;
    logic                        arst_n;
    t_rx_port                    rx;
    t_tx_port                    tx;
    logic                        busy;
    logic                        done;
    logic                        cfg_valid;
    t_cfg_addr                   cfg_addr;
    logic [`CCIP_CFG_DATA_W-1:0] cfg_data;
    logic                        mem_rsp_valid = 1'b0;
    logic [`CCIP_MDATA_W-1:0]    mem_rsp_mdata = '0;
    logic [`CCIP_DATA_W-1:0]     mem_rsp_data = '0;
    logic                        mem_ack_valid = 1'b0;
    logic [`CCIP_MDATA_W-1:0]    mem_ack_mdata = '0;

    // Memory contents and the bookkeeping of the current row
    logic [`CCIP_DATA_W-1:0]       mem [t_key];
    bit                            written [t_key];
    logic [`CCIP_DATA_W-1:0]       src_data [64];
    int                            rd_line_cnt [64];
    int                            rsp_cyc [64];
    t_key                          rd_key_q [$];
    logic [`CCIP_MDATA_W-1:0]      rd_tag_q [$];
    int                            rd_due_q [$];
    logic [`CCIP_MDATA_W-1:0]      ack_tag_q [$];
    int                            ack_due_q [$];
    logic [3:0][`CCIP_PPAGE_W-1:0] cur_pt;
    logic [`CCIP_VPAGE_W-1:0]      cur_src;
    logic [`CCIP_VPAGE_W-1:0]      cur_dst;
    t_len                          cur_len;
    t_row                          rows [4];
    int cyc = 0;
    int errors = 0;
    int start_cyc = 0;
    int reads_seen = 0;
    int acks_sent = 0;
    int last_ack_cyc = 0;
    int done_cnt = 0;

    ccip_lpbk_afu i_dut (
        .afu_clk (afu_clk),
        .arst_n  (arst_n),
        .rx      (rx),
        .tx      (tx),
        .busy    (busy),
        .done    (done)
    );

    // ====================
    // Clock and port
    // ====================

    always #50 afu_clk = ~afu_clk;

    always @(posedge afu_clk)
        cyc <= cyc + 1;

    // Configuration comes from the stimulus, responses from the memory model
    always_comb
    begin
        rx.cfg_valid    = cfg_valid;
        rx.cfg_addr     = cfg_addr;
        rx.cfg_data     = cfg_data;
        rx.rd_rsp_valid = mem_rsp_valid;
        rx.rd_rsp_mdata = mem_rsp_mdata;
        rx.rd_rsp_data  = mem_rsp_data;
        rx.wr_ack_valid = mem_ack_valid;
        rx.wr_ack_mdata = mem_ack_mdata;
    end

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp)
        begin
            errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    // One configuration write, at gives the cycle it was driven in
    task automatic cfg_write(input t_cfg_addr addr, input logic [31:0] data, output int at);
        @(negedge afu_clk);
        cfg_valid = 1'b1;
        cfg_addr  = addr;
        cfg_data  = data;
        at        = cyc;
        @(negedge afu_clk);
        cfg_valid = 1'b0;
    endtask

    task automatic run_watchdog(input int limit);
        repeat (limit) @(posedge afu_clk);
        $display("Watchdog expired after %0d cycles and the run did not finish", limit);
        $display("Errors: %0d value, %0d assertion", errors, i_dut.i_asserts.fail_cnt);
        $display("=== FAIL ===");
        $finish;
    endtask

    // ====================
    // Memory model
    // ====================

    // The tx bus is registered, so it is stable at the falling edge
    always @(negedge afu_clk)
    begin
        t_key key;
        int   pick;
        int   offs;
        mem_rsp_valid = 1'b0;
        mem_ack_valid = 1'b0;
        if (arst_n)
        begin
            if (tx.rd_valid)
            begin
                offs = int'(tx.rd_hdr.addr.offs);
                check("tx.rd_hdr.addr.page", tx.rd_hdr.addr.page, cur_pt[cur_src]);
                check("tx.rd_hdr.mdata", tx.rd_hdr.mdata, offs);
                if (reads_seen == 0)
                    check("tx.rd_valid delay", cyc - start_cyc, 4);
                if (offs >= int'(cur_len))
                begin
                    errors++;
                    $display("Read of line %0d lies past the requested length", offs);
                end
                else
                begin
                    rd_line_cnt[offs]++;
                end
                reads_seen++;
                rd_key_q.push_back(t_key'(tx.rd_hdr.addr));
                rd_tag_q.push_back(tx.rd_hdr.mdata);
                rd_due_q.push_back(cyc + 1 + int'($urandom % 8));
            end
            else
            begin
                // Idle read cycles carry an all zero header
                check("tx.rd_hdr", tx.rd_hdr, 64'h0);
            end
            if (tx.wr_valid)
            begin
                key  = t_key'(tx.wr_req.addr);
                offs = int'(tx.wr_req.addr.offs);
                check("tx.wr_req.addr.page", tx.wr_req.addr.page, cur_pt[cur_dst]);
                check("tx.wr_req.mdata", tx.wr_req.mdata, offs);
                check("tx.wr_req.data", tx.wr_req.data, src_data[offs]);
                check("tx.wr_valid delay", cyc - rsp_cyc[offs], 4);
                mem[key]     = tx.wr_req.data;
                written[key] = 1'b1;
                ack_tag_q.push_back(tx.wr_req.mdata);
                ack_due_q.push_back(cyc + 1 + int'($urandom % 8));
            end
            else
            begin
                // Idle write cycles carry an all zero request
                check("tx.wr_req.addr", tx.wr_req.addr, 64'h0);
                check("tx.wr_req.mdata", tx.wr_req.mdata, 64'h0);
                check("tx.wr_req.data", tx.wr_req.data, 64'h0);
            end

            // At most one read response per cycle, the first one that is due
            pick = -1;
            foreach (rd_due_q[i])
                if (pick < 0 && rd_due_q[i] <= cyc)
                    pick = i;
            if (pick >= 0)
            begin
                mem_rsp_valid = 1'b1;
                mem_rsp_mdata = rd_tag_q[pick];
                mem_rsp_data  = mem[rd_key_q[pick]];
                rsp_cyc[rd_tag_q[pick][`CCIP_OFFS_W-1:0]] = cyc;
                rd_key_q.delete(pick);
                rd_tag_q.delete(pick);
                rd_due_q.delete(pick);
            end

            pick = -1;
            foreach (ack_due_q[i])
                if (pick < 0 && ack_due_q[i] <= cyc)
                    pick = i;
            if (pick >= 0)
            begin
                mem_ack_valid = 1'b1;
                mem_ack_mdata = ack_tag_q[pick];
                acks_sent++;
                last_ack_cyc = cyc;
                ack_tag_q.delete(pick);
                ack_due_q.delete(pick);
            end

            // Done follows the last acknowledgement by two cycles, busy already low
            if (done)
            begin
                done_cnt++;
                check("acks before done", acks_sent, cur_len);
                check("done delay", cyc - last_ack_cyc, 2);
                check("busy", busy, 1'b0);
            end
        end
    end

    // ====================
    // Stimulus
    // ====================

    task automatic run_row(input t_row row);
        int   at;
        t_key key;
        cur_pt  = row.pt;
        cur_src = row.src;
        cur_dst = row.dst;
        cur_len = row.len;
        for (int e = 0; e < 4; e++)
            cfg_write(t_cfg_addr'(e), 32'(row.pt[e]), at);
        cfg_write(CFG_SRC, 32'(row.src), at);
        cfg_write(CFG_DST, 32'(row.dst), at);
        cfg_write(CFG_LEN, 32'(row.len), at);

        // Fresh source page and empty bookkeeping for this row
        written.delete();
        reads_seen = 0;
        acks_sent  = 0;
        done_cnt   = 0;
        for (int o = 0; o < 64; o++)
        begin
            rd_line_cnt[o] = 0;
            src_data[o]    = {$urandom, $urandom};
            mem[{row.pt[row.src], 6'(o)}] = src_data[o];
        end

        cfg_write(CFG_START, 32'd0, at);
        start_cyc = at;
        // A second start while busy must be ignored
        if (row.restart)
        begin
            repeat (3) @(negedge afu_clk);
            cfg_write(CFG_START, 32'd0, at);
        end
        wait (done_cnt != 0);
        // Drain so that stray requests would still be seen
        repeat (12) @(negedge afu_clk);

        check("done pulses", done_cnt, 1);
        check("read count", reads_seen, row.exp_reads);
        check("lines written", written.num(), row.len);
        for (int o = 0; o < int'(row.len); o++)
        begin
            key = {row.pt[row.dst], 6'(o)};
            check("reads of one line", rd_line_cnt[o], 1);
            if (!written.exists(key))
            begin
                errors++;
                $display("Destination line %0d was never written", o);
            end
            check("destination line", mem[key], src_data[o]);
        end
    endtask

    initial
    begin
        int limit;
        void'($urandom(36401));
        arst_n    = 1'b0;
        cfg_valid = 1'b0;
        cfg_addr  = '0;
        cfg_data  = '0;

        // Row 2 remaps virtual page 0, so its reads land on a new physical page
        rows[0] = '{pt: {20'h0A044, 20'h0A033, 20'h0A022, 20'h0A011}, src: 2'd0, dst: 2'd1,
                    len: 7'd8, restart: 1'b0, exp_reads: 7'd8};
        rows[1] = '{pt: {20'h0A044, 20'h0A033, 20'h0A022, 20'h0A011}, src: 2'd2, dst: 2'd3,
                    len: 7'd64, restart: 1'b1, exp_reads: 7'd64};
        rows[2] = '{pt: {20'h0A044, 20'h0A033, 20'h0A022, 20'h0B055}, src: 2'd0, dst: 2'd1,
                    len: 7'd5, restart: 1'b0, exp_reads: 7'd5};
        rows[3] = '{pt: {20'h0C004, 20'h0C003, 20'h0C002, 20'h0C001}, src: 2'd3, dst: 2'd0,
                    len: 7'd1, restart: 1'b1, exp_reads: 7'd1};

        limit = 200;
        foreach (rows[r])
            limit += 20 * int'(rows[r].len);
        fork
            run_watchdog(limit);
        join_none

        repeat (4) @(posedge afu_clk);
        @(negedge afu_clk);
        arst_n = 1'b1;

        foreach (rows[r])
            run_row(rows[r]);

        $display("Errors: %0d value, %0d assertion", errors, i_dut.i_asserts.fail_cnt);
        if (errors == 0 && i_dut.i_asserts.fail_cnt == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

/* verification/ccip_lpbk_asserts.sv */
// Protocol assertions for the loopback AFU top level
// Bound into every ccip_lpbk_afu instance, the testbench reads fail_cnt at the end

`timescale 1ns/1ps

module ccip_lpbk_asserts
    import ccip_lpbk_pkg::*;
(
    input logic     afu_clk,
    input logic     arst_n,
    input t_tx_port tx,
    input logic     busy,
    input logic     done
);

    int fail_cnt = 0;

    // Reads only leave the port while a command is running
    rd_only_busy: assert property (@(posedge afu_clk) disable iff (!arst_n)
        tx.rd_valid |-> busy)
    else
    begin
        fail_cnt++;
        $error("Read request seen on tx while the engine was idle");
    end

    // Done is a single cycle strobe
    done_one_cycle: assert property (@(posedge afu_clk) disable iff (!arst_n)
        done |=> !done)
    else
    begin
        fail_cnt++;
        $error("Done stayed high for more than one cycle");
    end

    // Writes only follow a running command, so none leaves the port straight out of reset
    wr_only_busy: assert property (@(posedge afu_clk) disable iff (!arst_n)
        tx.wr_valid |-> busy)
    else
    begin
        fail_cnt++;
        $error("Write request seen on tx while the engine was idle");
    end

endmodule

bind ccip_lpbk_afu ccip_lpbk_asserts i_asserts (
    .afu_clk (afu_clk),
    .arst_n  (arst_n),
    .tx      (tx),
    .busy    (busy),
    .done    (done)
);

/* source/ccip_lpbk_afu.sv */
// Top level of the loopback AFU
// Connects receive decode, the loopback engine, one translation stage
// per request channel and the transmit register
// Software programs the page table and command over rx, then waits for done

`timescale 1ns/1ps
`include "ccip_lpbk_defines.svh"

module ccip_lpbk_afu
    import ccip_lpbk_pkg::*;
(
    input  logic     afu_clk,
    input  logic     arst_n,
    input  t_rx_port rx,
    output t_tx_port tx,
    output logic     busy,
    output logic     done
);

    t_pt_write                pt_wr;
    t_lpbk_cmd                cmd;
    logic                     rd_rsp_valid;
    logic [`CCIP_MDATA_W-1:0] rd_rsp_mdata;
    logic [`CCIP_DATA_W-1:0]  rd_rsp_data;
    logic                     wr_ack_valid;

    // Engine side requests carry virtual addresses
    logic                     v_rd_valid;
    t_rd_req                  v_rd_req;
    logic                     v_wr_valid;
    t_wr_req                  v_wr_req;

    // Translated requests heading to the port
    logic                     p_rd_valid;
    t_rd_req                  p_rd_req;
    logic                     p_wr_valid;
    t_wr_req                  p_wr_req;

    ccip_rx_decode i_rx_decode (
        .afu_clk      (afu_clk),
        .arst_n       (arst_n),
        .rx           (rx),
        .pt_wr        (pt_wr),
        .cmd          (cmd),
        .rd_rsp_valid (rd_rsp_valid),
        .rd_rsp_mdata (rd_rsp_mdata),
        .rd_rsp_data  (rd_rsp_data),
        .wr_ack_valid (wr_ack_valid)
    );

    nlb_lpbk i_nlb (
        .afu_clk      (afu_clk),
        .arst_n       (arst_n),
        .cmd          (cmd),
        .rd_rsp_valid (rd_rsp_valid),
        .rd_rsp_mdata (rd_rsp_mdata),
        .rd_rsp_data  (rd_rsp_data),
        .wr_ack_valid (wr_ack_valid),
        .rd_valid     (v_rd_valid),
        .rd_req       (v_rd_req),
        .wr_valid     (v_wr_valid),
        .wr_req       (v_wr_req),
        .busy         (busy),
        .done         (done)
    );

    // Both stages see the same table writes, so their copies stay equal
    vtp_xlate #(.T_REQ(t_rd_req)) i_rd_xlate (
        .afu_clk   (afu_clk),
        .arst_n    (arst_n),
        .pt_wr     (pt_wr),
        .in_valid  (v_rd_valid),
        .in_req    (v_rd_req),
        .out_valid (p_rd_valid),
        .out_req   (p_rd_req)
    );

    vtp_xlate #(.T_REQ(t_wr_req)) i_wr_xlate (
        .afu_clk   (afu_clk),
        .arst_n    (arst_n),
        .pt_wr     (pt_wr),
        .in_valid  (v_wr_valid),
        .in_req    (v_wr_req),
        .out_valid (p_wr_valid),
        .out_req   (p_wr_req)
    );

    ccip_tx_encode i_tx_encode (
        .afu_clk  (afu_clk),
        .arst_n   (arst_n),
        .rd_valid (p_rd_valid),
        .rd_req   (p_rd_req),
        .wr_valid (p_wr_valid),
        .wr_req   (p_wr_req),
        .tx       (tx)
    );

endmodule

/* source/ccip_tx_encode.sv */
// Transmit side of the loopback AFU
// Registers the translated read and write requests onto the host port
// Payload fields read as zero in any cycle where their valid bit is low

`timescale 1ns/1ps
`include "ccip_lpbk_defines.svh"

module ccip_tx_encode
    import ccip_lpbk_pkg::*;
(
    input  logic     afu_clk,
    input  logic     arst_n,
    input  logic     rd_valid,
    input  t_rd_req  rd_req,
    input  logic     wr_valid,
    input  t_wr_req  wr_req,
    output t_tx_port tx
);

    // The port is an output register, so the whole bus starts clean
    always_ff @(posedge afu_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            tx <= '0;
        end
        else
        begin
            // Read channel
            tx.rd_valid <= rd_valid;
            tx.rd_hdr   <= rd_valid ? rd_req : '0;

            // Write channel
            tx.wr_valid <= wr_valid;
            tx.wr_req   <= wr_valid ? wr_req : '0;
        end
    end

endmodule

/* source/nlb_lpbk.sv */
// Loopback engine
// A start latches the command and issues one read per cycle over the source page
// Every read response becomes a write to the same offset in the destination page
// Done pulses once the last write acknowledgement has come back
// Addresses leave this block virtual and are translated downstream

`timescale 1ns/1ps
`include "ccip_lpbk_defines.svh"

module nlb_lpbk
    import ccip_lpbk_pkg::*;
(
    input  logic                     afu_clk,
    input  logic                     arst_n,
    input  t_lpbk_cmd                cmd,
    input  logic                     rd_rsp_valid,
    input  logic [`CCIP_MDATA_W-1:0] rd_rsp_mdata,
    input  logic [`CCIP_DATA_W-1:0]  rd_rsp_data,
    input  logic                     wr_ack_valid,
    output logic                     rd_valid,
    output t_rd_req                  rd_req,
    output logic                     wr_valid,
    output t_wr_req                  wr_req,
    output logic                     busy,
    output logic                     done
);

    logic [`CCIP_VPAGE_W-1:0] src_page_q;
    logic [`CCIP_VPAGE_W-1:0] dst_page_q;
    t_len                     len_q;
    t_len                     rd_cnt;
    t_len                     ack_cnt;
    logic                     start;
    logic                     issue;
    logic                     ack_last;
    t_vaddr                   rd_va;
    t_vaddr                   wr_va;
    logic [`CCIP_MDATA_W-1:0] rd_mdata;

    // A start while busy is dropped, as is a zero length
    assign start    = cmd.valid && !busy && (cmd.len != '0);
    assign issue    = start || (busy && (rd_cnt != len_q));
    assign ack_last = busy && wr_ack_valid && ((ack_cnt + 1'b1) == len_q);

    // ====================
    // Request addresses
    // ====================

    always_comb
    begin
        // Read 0 goes out straight from the command
        rd_va.page = start ? cmd.src_page : src_page_q;
        rd_va.offs = start ? '0 : rd_cnt[`CCIP_OFFS_W-1:0];

        // The read tag is the line index
        rd_mdata = '0;
        rd_mdata[`CCIP_OFFS_W-1:0] = rd_va.offs;

        // The response tag names the line, so order of return does not matter
        wr_va.page = dst_page_q;
        wr_va.offs = rd_rsp_mdata[`CCIP_OFFS_W-1:0];
    end

    // ====================
    // Control
    // ====================

    always_ff @(posedge afu_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            busy       <= 1'b0;
            done       <= 1'b0;
            rd_valid   <= 1'b0;
            wr_valid   <= 1'b0;
            rd_cnt     <= '0;
            ack_cnt    <= '0;
            src_page_q <= '0;
            dst_page_q <= '0;
            len_q      <= '0;
        end
        else
        begin
            rd_valid <= issue;
            wr_valid <= busy && rd_rsp_valid;
            done     <= ack_last;

            if (start)
            begin
                busy       <= 1'b1;
                src_page_q <= cmd.src_page;
                dst_page_q <= cmd.dst_page;
                len_q      <= cmd.len;
                // Read 0 is issued in this same cycle
                rd_cnt     <= t_len'(1);
                ack_cnt    <= '0;
            end
            else
            begin
                if (issue)
                    rd_cnt <= rd_cnt + 1'b1;
                if (busy && wr_ack_valid)
                    ack_cnt <= ack_cnt + 1'b1;
                if (ack_last)
                    busy <= 1'b0;
            end
        end
    end

    // Request payload, qualified by rd_valid and wr_valid
    always_ff @(posedge afu_clk)
    begin
        rd_req.addr  <= vaddr_to_line(rd_va);
        rd_req.mdata <= rd_mdata;
        wr_req.addr  <= vaddr_to_line(wr_va);
        wr_req.mdata <= rd_rsp_mdata;
        wr_req.data  <= rd_rsp_data;
    end

endmodule

/* source/vtp_xlate.sv */
// Virtual to physical translation stage with its own four entry page table
// The request type is a parameter, so one stage serves read headers and
// another serves write requests
// Any type with an addr field of t_paddr fits, the virtual page sits in its low bits
// Requests pass with one cycle of latency and a new one may enter every cycle

`timescale 1ns/1ps
`include "ccip_lpbk_defines.svh"

module vtp_xlate
    import ccip_lpbk_pkg::*;
#(
    parameter type T_REQ = t_rd_req
)
(
    input  logic      afu_clk,
    input  logic      arst_n,
    input  t_pt_write pt_wr,
    input  logic      in_valid,
    input  T_REQ      in_req,
    output logic      out_valid,
    output T_REQ      out_req
);

    logic [`CCIP_PPAGE_W-1:0] page_table [`CCIP_PT_ENTRIES];
    T_REQ                     xlated;

    // ====================
    // Page table
    // ====================

    // All entries read as page zero until software programs them
    always_ff @(posedge afu_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < `CCIP_PT_ENTRIES; i++)
                page_table[i] <= '0;
        end
        else if (pt_wr.valid)
        begin
            page_table[pt_wr.idx] <= pt_wr.ppage;
        end
    end

    // ====================
    // Translation
    // ====================

    // A write in this cycle only affects requests that arrive later
    always_comb
    begin
        xlated = in_req;
        xlated.addr.page = page_table[in_req.addr.page[`CCIP_VPAGE_W-1:0]];
    end

    always_ff @(posedge afu_clk or negedge arst_n)
    begin
        if (!arst_n)
            out_valid <= 1'b0;
        else
            out_valid <= in_valid;
    end

    // Payload follows the valid bit without reset
    always_ff @(posedge afu_clk)
    begin
        out_req <= xlated;
    end

endmodule

/* source/ccip_rx_decode.sv */
// Receive side of the loopback AFU
// Registers the host receive port and splits it into page table writes,
// a start command, read responses and write acknowledgements
// The start command carries the shadowed source, destination and length

`timescale 1ns/1ps
`include "ccip_lpbk_defines.svh"

module ccip_rx_decode
    import ccip_lpbk_pkg::*;
(
    input  logic                     afu_clk,
    input  logic                     arst_n,
    input  t_rx_port                 rx,
    output t_pt_write                pt_wr,
    output t_lpbk_cmd                cmd,
    output logic                     rd_rsp_valid,
    output logic [`CCIP_MDATA_W-1:0] rd_rsp_mdata,
    output logic [`CCIP_DATA_W-1:0]  rd_rsp_data,
    output logic                     wr_ack_valid
);

    logic                        cfg_valid_q;
    t_cfg_addr                   cfg_addr_q;
    logic [`CCIP_CFG_DATA_W-1:0] cfg_data_q;
    logic [`CCIP_VPAGE_W-1:0]    src_page_q;
    logic [`CCIP_VPAGE_W-1:0]    dst_page_q;
    t_len                        len_q;

    // Port strobes
    always_ff @(posedge afu_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            cfg_valid_q  <= 1'b0;
            rd_rsp_valid <= 1'b0;
            wr_ack_valid <= 1'b0;
        end
        else
        begin
            cfg_valid_q  <= rx.cfg_valid;
            rd_rsp_valid <= rx.rd_rsp_valid;
            wr_ack_valid <= rx.wr_ack_valid;
        end
    end

    // Port payload, qualified by the strobes above
    always_ff @(posedge afu_clk)
    begin
        cfg_addr_q   <= rx.cfg_addr;
        cfg_data_q   <= rx.cfg_data;
        rd_rsp_mdata <= rx.rd_rsp_mdata;
        rd_rsp_data  <= rx.rd_rsp_data;
    end

    // Shadow registers, read when a start arrives
    always_ff @(posedge afu_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            src_page_q <= '0;
            dst_page_q <= '0;
            len_q      <= '0;
        end
        else if (cfg_valid_q)
        begin
            if (cfg_addr_q == CFG_SRC)
                src_page_q <= cfg_data_q[`CCIP_VPAGE_W-1:0];
            else if (cfg_addr_q == CFG_DST)
                dst_page_q <= cfg_data_q[`CCIP_VPAGE_W-1:0];
            else if (cfg_addr_q == CFG_LEN)
                len_q <= cfg_data_q[`CCIP_LEN_W-1:0];
        end
    end

    // The low address bits select the table entry
    always_comb
    begin
        pt_wr.valid = cfg_valid_q && (cfg_addr_q <= CFG_PT_LAST);
        pt_wr.idx   = cfg_addr_q[`CCIP_VPAGE_W-1:0];
        pt_wr.ppage = cfg_data_q[`CCIP_PPAGE_W-1:0];

        cmd.valid    = cfg_valid_q && (cfg_addr_q == CFG_START);
        cmd.src_page = src_page_q;
        cmd.dst_page = dst_page_q;
        cmd.len      = len_q;
    end

endmodule

/* source/ccip_lpbk_pkg.sv */
// Packed types for the loopback AFU host port and its internal requests
// Modules take what they need through a wildcard import in their header
// The configuration address map also lives here as package constants

`include "ccip_lpbk_defines.svh"

package ccip_lpbk_pkg;

    // ====================
    // Addresses and requests
    // ====================

    typedef logic [`CCIP_CFG_ADDR_W-1:0] t_cfg_addr;
    typedef logic [`CCIP_LEN_W-1:0]      t_len;

    typedef struct packed {
        logic [`CCIP_VPAGE_W-1:0] page;
        logic [`CCIP_OFFS_W-1:0]  offs;
    } t_vaddr;

    typedef struct packed {
        logic [`CCIP_PPAGE_W-1:0] page;
        logic [`CCIP_OFFS_W-1:0]  offs;
    } t_paddr;

    // The address field holds either a virtual page in its low bits or a physical page
    typedef struct packed {
        t_paddr                   addr;
        logic [`CCIP_MDATA_W-1:0] mdata;
    } t_rd_req;

    typedef struct packed {
        t_paddr                   addr;
        logic [`CCIP_MDATA_W-1:0] mdata;
        logic [`CCIP_DATA_W-1:0]  data;
    } t_wr_req;

    // ====================
    // Host port
    // ====================

    typedef struct packed {
        logic                       cfg_valid;
        t_cfg_addr                  cfg_addr;
        logic [`CCIP_CFG_DATA_W-1:0] cfg_data;
        logic                       rd_rsp_valid;
        logic [`CCIP_MDATA_W-1:0]   rd_rsp_mdata;
        logic [`CCIP_DATA_W-1:0]    rd_rsp_data;
        logic                       wr_ack_valid;
        logic [`CCIP_MDATA_W-1:0]   wr_ack_mdata;
    } t_rx_port;

    typedef struct packed {
        logic    rd_valid;
        t_rd_req rd_hdr;
        logic    wr_valid;
        t_wr_req wr_req;
    } t_tx_port;

    // ====================
    // Configuration
    // ====================

    typedef struct packed {
        logic                     valid;
        logic [`CCIP_VPAGE_W-1:0] idx;
        logic [`CCIP_PPAGE_W-1:0] ppage;
    } t_pt_write;

    typedef struct packed {
        logic                     valid;
        logic [`CCIP_VPAGE_W-1:0] src_page;
        logic [`CCIP_VPAGE_W-1:0] dst_page;
        t_len                     len;
    } t_lpbk_cmd;

    // Addresses 0 up to CFG_PT_LAST write page table entries
    localparam t_cfg_addr CFG_PT_LAST = t_cfg_addr'(3);
    localparam t_cfg_addr CFG_SRC     = t_cfg_addr'(4);
    localparam t_cfg_addr CFG_DST     = t_cfg_addr'(5);
    localparam t_cfg_addr CFG_LEN     = t_cfg_addr'(6);
    localparam t_cfg_addr CFG_START   = t_cfg_addr'(7);

    // Places a virtual line address in the shared address field, page zero extended
    function automatic t_paddr vaddr_to_line(t_vaddr va);
        t_paddr line;
        line = '0;
        line.page[`CCIP_VPAGE_W-1:0] = va.page;
        line.offs = va.offs;
        return line;
    endfunction

endpackage

/* source/ccip_lpbk_defines.svh */
// Width and size macros shared by the loopback AFU and its testbench
// Include this header in any file that sizes a port or a field
// The package builds its structs from these values

`ifndef CCIP_LPBK_DEFINES_SVH
`define CCIP_LPBK_DEFINES_SVH

// Line data width in bits, a reduced line for this design
`define CCIP_DATA_W 64

// Line offset within a page, so a page holds 64 lines
`define CCIP_OFFS_W 6

// Virtual page number width, which sets the page table depth
`define CCIP_VPAGE_W 2
`define CCIP_PT_ENTRIES (1 << `CCIP_VPAGE_W)

// Physical page number width
`define CCIP_PPAGE_W 20

// Metadata tag carried by requests and echoed by responses
`define CCIP_MDATA_W 8

// Configuration bus address and value widths
`define CCIP_CFG_ADDR_W 4
`define CCIP_CFG_DATA_W 32

// Line count of a command, 1 to 64 lines
`define CCIP_LEN_W 7

`endif
